//--- Bender.yml
package:
  name: tpm_management

sources:
  - include_dirs:
      - include
    files:
      - source/tpm_mgmt_pkg.sv
      - source/op_state_fsm.sv
      - source/startup_decoder.sv
      - source/hierarchy_control.sv
      - source/response_code_unit.sv
      - source/tpm_management.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tpm_management_assert.sv
      - bench/tpm_management_tb.sv

//--- bench/tpm_management_assert.sv
`timescale 1ns/1ps

module tpm_management_assert (
	input logic                        clock,
	input logic                        reset_n,
	input logic                        key_start_n,
	input tpm_mgmt_pkg::op_state_t     op_state,
	input tpm_mgmt_pkg::startup_type_t startup_type,
	input tpm_mgmt_pkg::tpm_rc_t       tpm_rc,
	input logic                        ph_enable,
	input logic                        ph_enable_nv,
	input logic                        sh_enable,
	input logic                        eh_enable
);

	import tpm_mgmt_pkg::*;

	// Code 7 is not a state
	legal_state: assert property (@(posedge clock) disable iff (!reset_n) op_state != 3'd7)
		else $error("op_state holds an illegal code");

	// Only reset leaves failure mode
	failure_kept: assert property (@(posedge clock) disable iff (!reset_n)
		op_state == op_failure_mode |=> op_state == op_failure_mode)
		else $error("failure mode was left");

	// No step, no change
	stall_holds: assert property (@(posedge clock) disable iff (!reset_n)
		key_start_n |=> $stable({op_state, startup_type, tpm_rc,
			ph_enable, ph_enable_nv, sh_enable, eh_enable}))
		else $error("an output changed without a step");

	reset_enables: assert property (@(posedge clock)
		!reset_n |-> !(ph_enable || ph_enable_nv || sh_enable || eh_enable))
		else $error("an enable is set during reset");

endmodule

bind tpm_management tpm_management_assert tpm_management_assert_i (.*);

//--- bench/tpm_management_tb.sv
`timescale 1ns/1ps
`include "tpm_mgmt_config.svh"

module tpm_management_tb;

	import tpm_mgmt_pkg::*;

	// One snapshot of every DUT output
	typedef struct packed {
		op_state_t     st;
		tpm_rc_t       rc;
		startup_type_t ty;
		logic          ph;
		logic          ph_nv;
		logic          sh;
		logic          eh;
	} model_t;

	logic clock, reset_n, key_start_n, initialized;
	logic nv_ph_enable_nv, nv_sh_enable, nv_eh_enable;
	tpm_cc_t tpm_cc;
	tpm_rh_t auth_hierarchy;
	tpm_rc_t execution_rc;
	tpm_su_t orderly_input;
	logic [`TPM_PARAM_WIDTH-1:0] cmd_param;
	logic [`TPM_LOCALITY_WIDTH-1:0] locality;
	logic [`TPM_COUNT_WIDTH-1:0] tests_run, tests_passed, untested;
	op_state_t op_state;
	startup_type_t startup_type;
	tpm_rc_t tpm_rc;
	logic ph_enable, ph_enable_nv, sh_enable, eh_enable;

	model_t expected;
	string test_name = "reset";
	int errors = 0;
	int checks = 0;
	logic [31:0] rng = 32'd14;

	tpm_management tpm_management_i (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Next outputs after one step, from the management rules alone
	function automatic model_t next_model(input model_t m);
		model_t n;
		startup_type_t dec;
		tpm_rh_t h;
		logic yn, known_auth, hc;
		tpm_rc_t hrc;
		n = m;
		h = cmd_param[`TPM_PARAM_WIDTH-1:1];
		yn = cmd_param[0];
		if (orderly_input == tpm_su_state)
			dec = (cmd_param[15:0] == tpm_su_state) ? startup_resume : startup_restart;
		else
			dec = (cmd_param[15:0] == tpm_su_state) ? startup_invalid : startup_reset;
		known_auth = auth_hierarchy inside {tpm_rh_platform, tpm_rh_owner, tpm_rh_endorsement};
		hc = m.st == op_operational && tpm_cc == tpm_cc_hierarchy_control &&
			locality == `TPM_PLATFORM_LOCALITY && known_auth;
		if (auth_hierarchy == tpm_rh_platform)
			hrc = (h inside {tpm_rh_endorsement, tpm_rh_owner, tpm_rh_platform_nv} ||
				(h == tpm_rh_platform && !yn)) ? tpm_rc_success : tpm_rc_value;
		else if (h == auth_hierarchy && !yn)
			hrc = tpm_rc_success;
		else
			hrc = tpm_rc_auth_type;
		case (m.st)
			op_power_off: n.st = op_initialization;
			op_initialization: begin
				if (tpm_cc == tpm_cc_startup) n.st = op_startup;
				else n.rc = tpm_rc_initialize;
			end
			op_startup: begin
				n.ty = dec;
				if (initialized) begin
					n.st = op_operational;
					n.rc = tpm_rc_success;
				end else if (dec == startup_invalid) begin
					n.st = op_initialization;
					n.rc = tpm_rc_value;
				end
				if (dec != startup_invalid) begin
					n.ph = 1'b1;
					n.ph_nv = (dec == startup_resume) ? nv_ph_enable_nv : 1'b1;
					n.sh = (dec == startup_resume) ? nv_sh_enable : 1'b1;
					n.eh = (dec == startup_resume) ? nv_eh_enable : 1'b1;
				end
			end
			op_operational: begin
				if (tpm_cc inside {tpm_cc_self_test, tpm_cc_incremental_self_test})
					n.st = op_self_test;
				else if (tpm_cc == tpm_cc_shutdown)
					n.st = op_shutdown;
				n.rc = hc ? hrc : execution_rc;
				// Only successful requests touch an enable
				if (hc && hrc == tpm_rc_success) begin
					if (h == tpm_rh_endorsement) n.eh = yn;
					if (h == tpm_rh_owner) n.sh = yn;
					if (h == tpm_rh_platform_nv) n.ph_nv = yn;
					if (h == tpm_rh_platform) n.ph = 1'b0;
				end
			end
			op_self_test: begin
				n.rc = (tests_passed != tests_run) ? tpm_rc_failure : execution_rc;
				if (tests_passed != tests_run) n.st = op_failure_mode;
				else if (untested == 0) n.st = op_operational;
			end
			op_shutdown: n.st = op_operational;
			op_failure_mode: begin
				n.rc = (tpm_cc inside {tpm_cc_get_test_result, tpm_cc_get_capability}) ?
					execution_rc : tpm_rc_failure;
			end
			default: n.st = m.st;
		endcase
		return n;
	endfunction

	// Model state follows the DUT's step rule
	always @(posedge clock or negedge reset_n) begin
		if (!reset_n)
			expected <= '{op_power_off, tpm_rc_success, startup_done, 1'b0, 1'b0, 1'b0, 1'b0};
		else if (!key_start_n)
			expected <= next_model(expected);
	end

	//////////////////////////////
	// Checking
	//////////////////////////////

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	// Outputs are settled half a cycle after each edge
	always @(negedge clock) begin
		if (reset_n === 1'b1) begin
			check({test_name, " op_state"}, expected.st, op_state);
			check({test_name, " tpm_rc"}, expected.rc, tpm_rc);
			check({test_name, " startup_type"}, expected.ty, startup_type);
			check({test_name, " enables"}, {expected.ph, expected.ph_nv, expected.sh, expected.eh},
				{ph_enable, ph_enable_nv, sh_enable, eh_enable});
		end
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	task automatic step(input tpm_cc_t cc, input logic [`TPM_PARAM_WIDTH-1:0] param,
		input tpm_rh_t auth);
		@(negedge clock);
		tpm_cc = cc;
		cmd_param = param;
		auth_hierarchy = auth;
		key_start_n = 1'b0;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(negedge clock);
			key_start_n = 1'b1;
		end
	endtask

	task automatic wait_for_state(input op_state_t target, input int limit);
		int n;
		n = 0;
		idle(1);
		while (op_state !== target && n < limit) begin
			idle(1);
			n++;
		end
		if (op_state !== target) begin
			errors++;
			$display("Timeout: op_state never reached %s", target.name());
		end
	endtask

	task automatic apply_reset();
		int n;
		@(negedge clock);
		reset_n = 1'b0;
		key_start_n = 1'b1;
		n = 0;
		while (n < 16) begin
			@(negedge clock);
			n++;
		end
		reset_n = 1'b1;
	endtask

	initial begin
		int i;
		tpm_rh_t handles[4];
		tpm_rh_t auths[4];
		tpm_cc_t cmds[7];
		handles = '{tpm_rh_owner, tpm_rh_endorsement, tpm_rh_platform, tpm_rh_platform_nv};
		auths = '{tpm_rh_owner, tpm_rh_endorsement, tpm_rh_platform, 32'h4000_0007};
		cmds = '{tpm_cc_hierarchy_control, tpm_cc_incremental_self_test, tpm_cc_self_test,
			tpm_cc_startup, tpm_cc_shutdown, tpm_cc_get_test_result, tpm_cc_get_capability};
		reset_n = 1'b0;
		key_start_n = 1'b1;
		{tpm_cc, cmd_param, auth_hierarchy, execution_rc, orderly_input} = '0;
		{initialized, locality, tests_run, tests_passed, untested} = '0;
		{nv_ph_enable_nv, nv_sh_enable, nv_eh_enable} = '0;
		apply_reset();

		// Power-off, then commands refused before Startup
		idle(2);
		test_name = "init";
		step(tpm_cc_get_capability, '0, '0);
		step(tpm_cc_self_test, '0, '0);
		wait_for_state(op_initialization, 4);

		// Resume after a disorderly shutdown is refused
		test_name = "startup";
		step(tpm_cc_startup, 33'(tpm_su_state), '0);
		step(tpm_cc_startup, 33'(tpm_su_state), '0);
		wait_for_state(op_initialization, 4);
		// Inputs set right after a step already belong to that step
		step(tpm_cc_startup, 33'(tpm_su_state), '0);
		orderly_input = tpm_su_state;
		{nv_ph_enable_nv, nv_sh_enable, nv_eh_enable} = 3'b101;
		// Resume, then restart, then reset, and the last one completes
		step(tpm_cc_startup, 33'(tpm_su_state), '0);
		step(tpm_cc_startup, 33'(tpm_su_clear), '0);
		step(tpm_cc_startup, 33'(tpm_su_clear), '0);
		orderly_input = tpm_su_clear;
		step(tpm_cc_startup, 33'(tpm_su_clear), '0);
		initialized = 1'b1;
		wait_for_state(op_operational, 4);

		// Every handle, authorization and yes/no, then a foreign locality
		test_name = "hierarchy";
		locality = `TPM_PLATFORM_LOCALITY;
		for (i = 0; i < 32; i++) begin
			rng = xorshift(rng);
			execution_rc = rng;
			step(tpm_cc_hierarchy_control, {handles[i % 4], i[4]}, auths[(i / 4) % 4]);
		end
		locality = 8'd3;
		step(tpm_cc_hierarchy_control, {tpm_rh_owner, 1'b1}, tpm_rh_platform);

		test_name = "shutdown";
		step(tpm_cc_shutdown, '0, '0);
		idle(3);
		step(tpm_cc_get_capability, '0, '0);
		wait_for_state(op_operational, 4);

		// Incomplete, complete and failing self-tests
		test_name = "self_test";
		{tests_run, tests_passed, untested} = {16'd4, 16'd4, 16'd2};
		step(tpm_cc_self_test, '0, '0);
		step(tpm_cc_get_capability, '0, '0);
		step(tpm_cc_get_capability, '0, '0);
		untested = '0;
		wait_for_state(op_operational, 4);
		step(tpm_cc_incremental_self_test, '0, '0);
		tests_passed = 16'd3;
		step(tpm_cc_get_capability, '0, '0);
		wait_for_state(op_failure_mode, 4);
		test_name = "failure_mode";
		execution_rc = 32'h0000_0922;
		step(tpm_cc_get_test_result, '0, '0);
		step(tpm_cc_get_capability, '0, '0);
		step(tpm_cc_startup, '0, '0);
		idle(2);

		test_name = "random";
		apply_reset();
		for (i = 0; i < 500; i++) begin
			rng = xorshift(rng);
			tpm_cc = (rng[3:0] < 4'd13) ? cmds[rng[6:4] % 7] : rng;
			key_start_n = rng[7] & rng[8];
			orderly_input = 16'(rng[9]);
			initialized = rng[10] & rng[11];
			locality = rng[12] ? `TPM_PLATFORM_LOCALITY : 8'(rng[15:13]);
			auth_hierarchy = auths[rng[17:16]];
			{nv_ph_enable_nv, nv_sh_enable, nv_eh_enable} = rng[20:18];
			tests_run = 16'(rng[23:21]);
			tests_passed = (rng[27:24] == 4'd0) ? tests_run + 16'd1 : tests_run;
			untested = 16'(rng[29:28]);
			rng = xorshift(rng);
			execution_rc = rng;
			cmd_param = rng[31] ? {handles[rng[1:0]], rng[2]} : 33'(rng[0]);
			@(negedge clock);
		end
		idle(2);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Limit on the whole run
	initial begin
		#200000;
		$display("Simulation did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

endmodule

//--- build.f
+incdir+include
source/tpm_mgmt_pkg.sv
source/op_state_fsm.sv
source/startup_decoder.sv
source/hierarchy_control.sv
source/response_code_unit.sv
source/tpm_management.sv
bench/tpm_management_assert.sv
bench/tpm_management_tb.sv

//--- include/tpm_mgmt_config.svh
`ifndef TPM_MGMT_CONFIG_SVH
`define TPM_MGMT_CONFIG_SVH

//////////////////////////////
// Widths of the TPM management datapath
//////////////////////////////

// Command codes, response codes and hierarchy handles are all one TPM word
`define TPM_WORD_WIDTH 32

// Low slice of the command parameters seen by this block
// Bits 32..1 carry a handle and bit 0 carries the yes/no flag
`define TPM_PARAM_WIDTH 33

// Self-test bookkeeping counters from the self-test engine
`define TPM_COUNT_WIDTH 16

// Locality of the command as reported by the I/O interface
`define TPM_LOCALITY_WIDTH 8

// Only this locality may issue hierarchy control
`define TPM_PLATFORM_LOCALITY 1

`endif

//--- source/hierarchy_control.sv
`timescale 1ns/1ps
`include "tpm_mgmt_config.svh"

module hierarchy_control (
	input  logic                           clock,
	input  logic                           reset_n,
	input  logic                           key_start_n,
	input  tpm_mgmt_pkg::op_state_t        op_state,
	input  tpm_mgmt_pkg::startup_type_t    startup_decoded,
	input  tpm_mgmt_pkg::tpm_cc_t          tpm_cc,
	input  logic [`TPM_LOCALITY_WIDTH-1:0] locality,
	input  tpm_mgmt_pkg::tpm_rh_t          auth_hierarchy,
	input  logic [`TPM_PARAM_WIDTH-1:0]    cmd_param,
	input  logic                           nv_ph_enable_nv,
	input  logic                           nv_sh_enable,
	input  logic                           nv_eh_enable,
	output logic                           ph_enable,
	output logic                           ph_enable_nv,
	output logic                           sh_enable,
	output logic                           eh_enable,
	output logic                           hc_request,
	output tpm_mgmt_pkg::tpm_rc_t          hc_rc
);

	import tpm_mgmt_pkg::*;

	tpm_rh_t enable_handle;
	logic    yes_no;
	logic    platform_auth;
	logic    owner_auth;
	logic    endorsement_auth;
	logic    platform_ok;
	logic    owner_clear;
	logic    endorsement_clear;
	logic    ph_next;
	logic    ph_nv_next;
	logic    sh_next;
	logic    eh_next;

	//////////////////////////////
	// Request decode
	//////////////////////////////

	// The enable handle sits above the yes/no flag in the parameter slice
	assign enable_handle = cmd_param[`TPM_PARAM_WIDTH-1:1];
	assign yes_no        = cmd_param[0];

	assign platform_auth    = (auth_hierarchy == tpm_rh_platform);
	assign owner_auth       = (auth_hierarchy == tpm_rh_owner);
	assign endorsement_auth = (auth_hierarchy == tpm_rh_endorsement);

	// Platform may switch the other three either way but may only turn itself off
	assign platform_ok = platform_auth &&
		(enable_handle == tpm_rh_endorsement || enable_handle == tpm_rh_owner ||
		 enable_handle == tpm_rh_platform_nv ||
		 (enable_handle == tpm_rh_platform && !yes_no));

	// Owner and endorsement may only clear their own enable
	assign owner_clear       = owner_auth && enable_handle == tpm_rh_owner && !yes_no;
	assign endorsement_clear = endorsement_auth && enable_handle == tpm_rh_endorsement && !yes_no;

	// Only requests from a known hierarchy are judged here
	// Everything else is left to the execution engine's code
	assign hc_request = (op_state == op_operational) && (tpm_cc == tpm_cc_hierarchy_control) &&
		(locality == platform_locality) && (platform_auth || owner_auth || endorsement_auth);

	// Result code of a request, only looked at while hc_request is set
	always_comb begin
		if (platform_auth) begin
			hc_rc = platform_ok ? tpm_rc_success : tpm_rc_value;
		end else if (owner_clear || endorsement_clear) begin
			hc_rc = tpm_rc_success;
		end else begin
			hc_rc = tpm_rc_auth_type;
		end
	end

	//////////////////////////////
	// Enable update
	//////////////////////////////

	always_comb begin
		ph_next    = ph_enable;
		ph_nv_next = ph_enable_nv;
		sh_next    = sh_enable;
		eh_next    = eh_enable;
		if (op_state == op_startup && startup_decoded != startup_invalid) begin
			// A valid startup always turns the platform hierarchy on
			ph_next = 1'b1;
			if (startup_decoded == startup_resume) begin
				// Resume restores what was saved in NV memory
				ph_nv_next = nv_ph_enable_nv;
				sh_next    = nv_sh_enable;
				eh_next    = nv_eh_enable;
			end else begin
				ph_nv_next = 1'b1;
				sh_next    = 1'b1;
				eh_next    = 1'b1;
			end
		end else if (hc_request) begin
			if (platform_auth) begin
				if (enable_handle == tpm_rh_endorsement) begin
					eh_next = yes_no;
				end else if (enable_handle == tpm_rh_owner) begin
					sh_next = yes_no;
				end else if (enable_handle == tpm_rh_platform_nv) begin
					ph_nv_next = yes_no;
				end else if (enable_handle == tpm_rh_platform && !yes_no) begin
					ph_next = 1'b0;
				end
			end else if (owner_clear) begin
				sh_next = 1'b0;
			end else if (endorsement_clear) begin
				eh_next = 1'b0;
			end
		end
	end

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			ph_enable    <= 1'b0;
			ph_enable_nv <= 1'b0;
			sh_enable    <= 1'b0;
			eh_enable    <= 1'b0;
		end else if (!key_start_n) begin
			ph_enable    <= ph_next;
			ph_enable_nv <= ph_nv_next;
			sh_enable    <= sh_next;
			eh_enable    <= eh_next;
		end
	end

endmodule

//--- source/op_state_fsm.sv
`timescale 1ns/1ps
`include "tpm_mgmt_config.svh"

module op_state_fsm (
	input  logic                        clock,
	input  logic                        reset_n,
	input  logic                        key_start_n,
	input  tpm_mgmt_pkg::tpm_cc_t       tpm_cc,
	input  logic                        initialized,
	input  tpm_mgmt_pkg::startup_type_t startup_decoded,
	input  logic [`TPM_COUNT_WIDTH-1:0] tests_run,
	input  logic [`TPM_COUNT_WIDTH-1:0] tests_passed,
	input  logic [`TPM_COUNT_WIDTH-1:0] untested,
	output tpm_mgmt_pkg::op_state_t     op_state
);

	import tpm_mgmt_pkg::*;

	op_state_t state_next;

	//////////////////////////////
	// Transition rules
	//////////////////////////////

	// Every state holds unless one of its rules fires
	always_comb begin
		state_next = op_state;
		case (op_state)
			// Power-off always moves straight on to initialization
			op_power_off: begin
				state_next = op_initialization;
			end
			// Only a Startup command leaves initialization
			op_initialization: begin
				if (tpm_cc == tpm_cc_startup) begin
					state_next = op_startup;
				end
			end
			// The engine reporting initialized wins over a bad startup type
			op_startup: begin
				if (initialized) begin
					state_next = op_operational;
				end else if (startup_decoded == startup_invalid) begin
					state_next = op_initialization;
				end
			end
			op_operational: begin
				if (tpm_cc == tpm_cc_self_test || tpm_cc == tpm_cc_incremental_self_test) begin
					state_next = op_self_test;
				end else if (tpm_cc == tpm_cc_shutdown) begin
					state_next = op_shutdown;
				end
			end
			// Any failed test sends the TPM into failure mode
			// With no failures it returns once nothing is left untested
			op_self_test: begin
				if (tests_passed != tests_run) begin
					state_next = op_failure_mode;
				end else if (untested == '0) begin
					state_next = op_operational;
				end
			end
			// Shutdown lasts exactly one step
			op_shutdown: begin
				state_next = op_operational;
			end
			// Failure mode is absorbing and only reset leaves it
			op_failure_mode: begin
				state_next = op_failure_mode;
			end
			default: begin
				state_next = op_power_off;
			end
		endcase
	end

	// State register advances only on a step
	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			op_state <= op_power_off;
		end else if (!key_start_n) begin
			op_state <= state_next;
		end
	end

endmodule

//--- source/response_code_unit.sv
`timescale 1ns/1ps
`include "tpm_mgmt_config.svh"

module response_code_unit (
	input  logic                        clock,
	input  logic                        reset_n,
	input  logic                        key_start_n,
	input  tpm_mgmt_pkg::op_state_t     op_state,
	input  tpm_mgmt_pkg::tpm_cc_t       tpm_cc,
	input  tpm_mgmt_pkg::startup_type_t startup_decoded,
	input  logic                        initialized,
	input  tpm_mgmt_pkg::tpm_rc_t       execution_rc,
	input  logic [`TPM_COUNT_WIDTH-1:0] tests_run,
	input  logic [`TPM_COUNT_WIDTH-1:0] tests_passed,
	input  logic                        hc_request,
	input  tpm_mgmt_pkg::tpm_rc_t       hc_rc,
	output tpm_mgmt_pkg::tpm_rc_t       tpm_rc
);

	import tpm_mgmt_pkg::*;

	tpm_rc_t rc_next;

	// Code chosen by the state the step is taken in
	// Power-off and shutdown keep whatever was reported last
	always_comb begin
		rc_next = tpm_rc;
		case (op_state)
			op_initialization: begin
				if (tpm_cc != tpm_cc_startup) begin
					rc_next = tpm_rc_initialize;
				end
			end
			op_startup: begin
				if (initialized) begin
					rc_next = tpm_rc_success;
				end else if (startup_decoded == startup_invalid) begin
					rc_next = tpm_rc_value;
				end
			end
			// Hierarchy control answers for itself, other commands come from the engine
			op_operational: begin
				rc_next = hc_request ? hc_rc : execution_rc;
			end
			op_self_test: begin
				rc_next = (tests_passed != tests_run) ? tpm_rc_failure : execution_rc;
			end
			// Only the diagnostic commands still get through in failure mode
			op_failure_mode: begin
				if (tpm_cc == tpm_cc_get_test_result || tpm_cc == tpm_cc_get_capability) begin
					rc_next = execution_rc;
				end else begin
					rc_next = tpm_rc_failure;
				end
			end
			default: begin
				rc_next = tpm_rc;
			end
		endcase
	end

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			tpm_rc <= tpm_rc_success;
		end else if (!key_start_n) begin
			tpm_rc <= rc_next;
		end
	end

endmodule

//--- source/startup_decoder.sv
`timescale 1ns/1ps

module startup_decoder (
	input  logic                        clock,
	input  logic                        reset_n,
	input  logic                        key_start_n,
	input  tpm_mgmt_pkg::op_state_t     op_state,
	input  tpm_mgmt_pkg::tpm_su_t       startup_param,
	input  tpm_mgmt_pkg::tpm_su_t       orderly_input,
	output tpm_mgmt_pkg::startup_type_t startup_decoded,
	output tpm_mgmt_pkg::startup_type_t startup_type
);

	import tpm_mgmt_pkg::*;

	// Startup type from the orderly state of the last shutdown and the
	// parameter of the present Startup command
	// A state resume after a disorderly shutdown cannot be honoured
	always_comb begin
		if (orderly_input == tpm_su_state) begin
			startup_decoded = (startup_param == tpm_su_state) ? startup_resume : startup_restart;
		end else begin
			startup_decoded = (startup_param == tpm_su_state) ? startup_invalid : startup_reset;
		end
	end

	// Keeps the type of the last step taken in the startup state
	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			startup_type <= startup_done;
		end else if (!key_start_n && op_state == op_startup) begin
			startup_type <= startup_decoded;
		end
	end

endmodule

//--- source/tpm_management.sv
`timescale 1ns/1ps
`include "tpm_mgmt_config.svh"

module tpm_management (
	input  logic                           clock,
	input  logic                           reset_n,
	input  logic                           key_start_n,
	input  tpm_mgmt_pkg::tpm_cc_t          tpm_cc,
	input  logic [`TPM_PARAM_WIDTH-1:0]    cmd_param,
	input  tpm_mgmt_pkg::tpm_su_t          orderly_input,
	input  logic                           initialized,
	input  tpm_mgmt_pkg::tpm_rh_t          auth_hierarchy,
	input  tpm_mgmt_pkg::tpm_rc_t          execution_rc,
	input  logic [`TPM_LOCALITY_WIDTH-1:0] locality,
	input  logic [`TPM_COUNT_WIDTH-1:0]    tests_run,
	input  logic [`TPM_COUNT_WIDTH-1:0]    tests_passed,
	input  logic [`TPM_COUNT_WIDTH-1:0]    untested,
	input  logic                           nv_ph_enable_nv,
	input  logic                           nv_sh_enable,
	input  logic                           nv_eh_enable,
	output tpm_mgmt_pkg::op_state_t        op_state,
	output tpm_mgmt_pkg::startup_type_t    startup_type,
	output tpm_mgmt_pkg::tpm_rc_t          tpm_rc,
	output logic                           ph_enable,
	output logic                           ph_enable_nv,
	output logic                           sh_enable,
	output logic                           eh_enable
);

	import tpm_mgmt_pkg::*;

	// Decoded startup type, live every cycle
	startup_type_t startup_decoded;
	// Hierarchy-control decision passed to the response code
	logic          hc_request;
	tpm_rc_t       hc_rc;

	op_state_fsm op_state_fsm_i (
		.clock           (clock),
		.reset_n         (reset_n),
		.key_start_n     (key_start_n),
		.tpm_cc          (tpm_cc),
		.initialized     (initialized),
		.startup_decoded (startup_decoded),
		.tests_run       (tests_run),
		.tests_passed    (tests_passed),
		.untested        (untested),
		.op_state        (op_state)
	);

	// The startup parameter is the low half-word of the command parameters
	startup_decoder startup_decoder_i (
		.clock           (clock),
		.reset_n         (reset_n),
		.key_start_n     (key_start_n),
		.op_state        (op_state),
		.startup_param   (cmd_param[15:0]),
		.orderly_input   (orderly_input),
		.startup_decoded (startup_decoded),
		.startup_type    (startup_type)
	);

	hierarchy_control hierarchy_control_i (
		.clock           (clock),
		.reset_n         (reset_n),
		.key_start_n     (key_start_n),
		.op_state        (op_state),
		.startup_decoded (startup_decoded),
		.tpm_cc          (tpm_cc),
		.locality        (locality),
		.auth_hierarchy  (auth_hierarchy),
		.cmd_param       (cmd_param),
		.nv_ph_enable_nv (nv_ph_enable_nv),
		.nv_sh_enable    (nv_sh_enable),
		.nv_eh_enable    (nv_eh_enable),
		.ph_enable       (ph_enable),
		.ph_enable_nv    (ph_enable_nv),
		.sh_enable       (sh_enable),
		.eh_enable       (eh_enable),
		.hc_request      (hc_request),
		.hc_rc           (hc_rc)
	);

	response_code_unit response_code_unit_i (
		.clock           (clock),
		.reset_n         (reset_n),
		.key_start_n     (key_start_n),
		.op_state        (op_state),
		.tpm_cc          (tpm_cc),
		.startup_decoded (startup_decoded),
		.initialized     (initialized),
		.execution_rc    (execution_rc),
		.tests_run       (tests_run),
		.tests_passed    (tests_passed),
		.hc_request      (hc_request),
		.hc_rc           (hc_rc),
		.tpm_rc          (tpm_rc)
	);

endmodule

//--- source/tpm_mgmt_pkg.sv
`include "tpm_mgmt_config.svh"

package tpm_mgmt_pkg;

	//////////////////////////////
	// Types
	//////////////////////////////

	// Operational states of the TPM, code 7 is never used
	typedef enum logic [2:0] {
		op_power_off      = 3'd0,
		op_initialization = 3'd1,
		op_startup        = 3'd2,
		op_operational    = 3'd3,
		op_self_test      = 3'd4,
		op_failure_mode   = 3'd5,
		op_shutdown       = 3'd6
	} op_state_t;

	// Startup type handed to the execution engine
	// Invalid marks a resume request after a disorderly shutdown
	typedef enum logic [2:0] {
		startup_done    = 3'd0,
		startup_reset   = 3'd1,
		startup_restart = 3'd2,
		startup_resume  = 3'd3,
		startup_invalid = 3'd4
	} startup_type_t;

	typedef logic [`TPM_WORD_WIDTH-1:0] tpm_cc_t;
	typedef logic [`TPM_WORD_WIDTH-1:0] tpm_rc_t;
	typedef logic [`TPM_WORD_WIDTH-1:0] tpm_rh_t;
	typedef logic [15:0] tpm_su_t;

	//////////////////////////////
	// TPM constants
	//////////////////////////////

	// Command codes this block reacts to
	localparam tpm_cc_t tpm_cc_hierarchy_control    = 32'h0000_0121;
	localparam tpm_cc_t tpm_cc_incremental_self_test = 32'h0000_0142;
	localparam tpm_cc_t tpm_cc_self_test            = 32'h0000_0143;
	localparam tpm_cc_t tpm_cc_startup              = 32'h0000_0144;
	localparam tpm_cc_t tpm_cc_shutdown             = 32'h0000_0145;
	localparam tpm_cc_t tpm_cc_get_capability       = 32'h0000_017A;
	localparam tpm_cc_t tpm_cc_get_test_result      = 32'h0000_017C;

	// Response codes produced here rather than by the execution engine
	localparam tpm_rc_t tpm_rc_success   = 32'h0000_0000;
	localparam tpm_rc_t tpm_rc_value     = 32'h0000_0084;
	localparam tpm_rc_t tpm_rc_initialize = 32'h0000_0100;
	localparam tpm_rc_t tpm_rc_failure   = 32'h0000_0101;
	localparam tpm_rc_t tpm_rc_auth_type = 32'h0000_0124;

	// Hierarchy handles, used both as authorization and as enable target
	localparam tpm_rh_t tpm_rh_owner       = 32'h4000_0001;
	localparam tpm_rh_t tpm_rh_endorsement = 32'h4000_000B;
	localparam tpm_rh_t tpm_rh_platform    = 32'h4000_000C;
	localparam tpm_rh_t tpm_rh_platform_nv = 32'h4000_000D;

	// Startup and shutdown parameters
	localparam tpm_su_t tpm_su_clear = 16'h0000;
	localparam tpm_su_t tpm_su_state = 16'h0001;

	// Locality allowed to change the hierarchy enables
	localparam logic [`TPM_LOCALITY_WIDTH-1:0] platform_locality = `TPM_PLATFORM_LOCALITY;

endpackage
